/* verilog/id_pkg.sv */
// Shared definitions for the decode stage
// Vector types, base opcodes, funct codes, FU and operation encodings,
// exception causes and the structs passed between the decode blocks

package id_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;
  typedef logic [15:0] cinstr_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [31:0] imm_t;
  typedef logic [2:0]  fu_t;
  typedef logic [4:0]  op_t;
  typedef logic [3:0]  exc_cause_t;
  typedef logic [1:0]  priv_lvl_t;

  // ----------------------------------------
  // Base opcodes and function fields
  // ----------------------------------------
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;
  localparam logic [2:0] F3_JALR = 3'b000;
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  // Word access for LW and SW
  localparam logic [2:0] F3_WORD = 3'b010;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  // SYSTEM words are matched in full
  localparam instr_t INSTR_ECALL = 32'h0000_0073;
  localparam instr_t INSTR_MRET  = 32'h3020_0073;

  // ----------------------------------------
  // Functional units and operations
  // ----------------------------------------
  localparam fu_t FU_NONE      = 3'd0;
  localparam fu_t FU_ALU       = 3'd1;
  localparam fu_t FU_CTRL_FLOW = 3'd2;
  localparam fu_t FU_LOAD      = 3'd3;
  localparam fu_t FU_STORE     = 3'd4;
  localparam fu_t FU_CSR       = 3'd5;

  localparam op_t OP_ADD   = 5'd0;
  localparam op_t OP_SUB   = 5'd1;
  localparam op_t OP_SLT   = 5'd2;
  localparam op_t OP_XOR   = 5'd3;
  localparam op_t OP_OR    = 5'd4;
  localparam op_t OP_AND   = 5'd5;
  localparam op_t OP_JAL   = 5'd6;
  localparam op_t OP_JALR  = 5'd7;
  localparam op_t OP_BEQ   = 5'd8;
  localparam op_t OP_BNE   = 5'd9;
  localparam op_t OP_BLT   = 5'd10;
  localparam op_t OP_BGE   = 5'd11;
  localparam op_t OP_LW    = 5'd12;
  localparam op_t OP_SW    = 5'd13;
  localparam op_t OP_ECALL = 5'd14;
  localparam op_t OP_MRET  = 5'd15;

  localparam exc_cause_t CAUSE_ILLEGAL_INSTR    = 4'd2;
  localparam exc_cause_t CAUSE_ECALL_U          = 4'd8;
  localparam exc_cause_t CAUSE_ECALL_M          = 4'd11;
  localparam exc_cause_t CAUSE_INSTR_PAGE_FAULT = 4'd12;

  localparam priv_lvl_t PRIV_U = 2'd0;
  localparam priv_lvl_t PRIV_M = 2'd3;

  // ----------------------------------------
  // Structs
  // ----------------------------------------
  typedef struct packed {
    addr_t  address;
    instr_t instruction;
    logic   ex_valid;
  } fetch_entry_t;

  typedef struct packed {
    instr_t instr;
    logic   is_compressed;
    logic   illegal;
  } expanded_instr_t;

  typedef struct packed {
    addr_t      pc;
    fu_t        fu;
    op_t        op;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    imm_t       imm;
    logic       use_imm;
    logic       is_compressed;
    logic       ex_valid;
    exc_cause_t ex_cause;
  } sb_entry_t;

  typedef struct packed {
    logic      valid;
    sb_entry_t sbe;
    instr_t    orig_instr;
    logic      is_ctrl_flow;
  } issue_slot_t;

endpackage

/* verilog/compressed_decoder.sv */
`timescale 1ns/1ns
// RVC expander
// Maps C.ADDI, C.LI, C.MV, C.ADD, C.J, C.BEQZ, C.BNEZ, C.LW and C.SW
// onto their 32-bit forms and flags every other 16-bit encoding

module compressed_decoder #(
  parameter bit RvcEn = 1'b1
) (
  input  id_pkg::instr_t          instr_i,
  output id_pkg::expanded_instr_t exp_o
);
  import id_pkg::*;

  cinstr_t     c;
  reg_idx_t    rd_full;
  reg_idx_t    rs2_full;
  reg_idx_t    rs1_prime;
  reg_idx_t    rs2_prime;
  logic [11:0] ci_imm;
  logic [11:0] mem_imm;
  logic [6:0]  b_hi;
  logic [4:0]  b_lo;
  logic [19:0] j_enc;

  assign c = instr_i[15:0];

  // Full register fields and the x8..x15 short forms
  assign rd_full   = c[11:7];
  assign rs2_full  = c[6:2];
  assign rs1_prime = {2'b01, c[9:7]};
  assign rs2_prime = {2'b01, c[4:2]};

  // ----------------------------------------
  // Immediates, already in 32-bit field order
  // ----------------------------------------
  assign ci_imm  = {{7{c[12]}}, c[6:2]};
  assign mem_imm = {5'b00000, c[5], c[12:10], c[6], 2'b00};

  // Branch offset split into the B-type upper and lower fields
  assign b_hi = {{4{c[12]}}, c[6:5], c[2]};
  assign b_lo = {c[11:10], c[4:3], c[12]};

  // Jump offset in the J-type order imm[20|10:1|11|19:12]
  assign j_enc = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], {9{c[12]}}};

  always_comb begin
    exp_o.instr         = instr_i;
    exp_o.is_compressed = 1'b0;
    exp_o.illegal       = 1'b0;

    if (RvcEn && (instr_i[1:0] != 2'b11)) begin
      exp_o.instr         = {16'h0000, c};
      exp_o.is_compressed = 1'b1;

      // Quadrant and funct3 select the encoding
      case ({c[1:0], c[15:13]})
        // C.ADDI
        5'b01_000: exp_o.instr = {ci_imm, rd_full, F3_ADD, rd_full, OPC_OP_IMM};
        // C.LI
        5'b01_010: exp_o.instr = {ci_imm, 5'd0, F3_ADD, rd_full, OPC_OP_IMM};
        // C.J links to x0
        5'b01_101: exp_o.instr = {j_enc, 5'd0, OPC_JAL};
        // C.BEQZ and C.BNEZ compare against x0
        5'b01_110: exp_o.instr = {b_hi, 5'd0, rs1_prime, F3_BEQ, b_lo, OPC_BRANCH};
        5'b01_111: exp_o.instr = {b_hi, 5'd0, rs1_prime, F3_BNE, b_lo, OPC_BRANCH};
        // C.LW and C.SW use the short base register
        5'b00_010: exp_o.instr = {mem_imm, rs1_prime, F3_WORD, rs2_prime, OPC_LOAD};
        5'b00_110: begin
          exp_o.instr = {mem_imm[11:5], rs2_prime, rs1_prime, F3_WORD, mem_imm[4:0],
                         OPC_STORE};
        end
        5'b10_100: begin
          // rs2 of zero is C.JR, C.JALR or C.EBREAK, none of them kept
          if (rs2_full == 5'd0) begin
            exp_o.illegal = 1'b1;
          end else if (c[12]) begin
            exp_o.instr = {F7_BASE, rs2_full, rd_full, F3_ADD, rd_full, OPC_OP};
          end else begin
            exp_o.instr = {F7_BASE, rs2_full, 5'd0, F3_ADD, rd_full, OPC_OP};
          end
        end
        // The all-zero half-word lands here too
        default: exp_o.illegal = 1'b1;
      endcase
    end
  end

endmodule

/* verilog/instr_decoder.sv */
`timescale 1ns/1ns
// RV32I subset decoder
// Produces the scoreboard entry and the control-flow flag, and merges
// fetch, illegal-instruction and ECALL exceptions by priority

module instr_decoder (
  input  id_pkg::expanded_instr_t exp_i,
  input  id_pkg::addr_t           pc_i,
  input  logic                    fetch_ex_i,
  input  id_pkg::priv_lvl_t       priv_lvl_i,
  output id_pkg::sb_entry_t       sbe_o,
  output logic                    is_ctrl_flow_o
);
  import id_pkg::*;

  instr_t    w;
  sb_entry_t dec;
  imm_t      imm_i;
  imm_t      imm_s;
  imm_t      imm_b;
  imm_t      imm_u;
  imm_t      imm_j;
  logic      undecoded;
  logic      ecall;
  logic      mret;
  logic      illegal;

  assign w = exp_i.instr;

  assign imm_i = {{20{w[31]}}, w[31:20]};
  assign imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
  assign imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
  assign imm_u = {w[31:12], 12'h000};
  assign imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};

  // ----------------------------------------
  // Opcode decode
  // ----------------------------------------
  always_comb begin
    dec       = '0;
    undecoded = 1'b0;
    ecall     = 1'b0;
    mret      = 1'b0;

    case (w[6:0])
      OPC_OP_IMM: begin
        dec.fu      = FU_ALU;
        dec.rd      = w[11:7];
        dec.rs1     = w[19:15];
        dec.imm     = imm_i;
        dec.use_imm = 1'b1;
        case (w[14:12])
          F3_ADD:  dec.op = OP_ADD;
          F3_SLT:  dec.op = OP_SLT;
          F3_XOR:  dec.op = OP_XOR;
          F3_OR:   dec.op = OP_OR;
          F3_AND:  dec.op = OP_AND;
          default: undecoded = 1'b1;
        endcase
      end
      OPC_OP: begin
        dec.fu  = FU_ALU;
        dec.rd  = w[11:7];
        dec.rs1 = w[19:15];
        dec.rs2 = w[24:20];
        case ({w[31:25], w[14:12]})
          {F7_BASE, F3_ADD}: dec.op = OP_ADD;
          {F7_SUB, F3_ADD}:  dec.op = OP_SUB;
          {F7_BASE, F3_SLT}: dec.op = OP_SLT;
          {F7_BASE, F3_XOR}: dec.op = OP_XOR;
          {F7_BASE, F3_OR}:  dec.op = OP_OR;
          {F7_BASE, F3_AND}: dec.op = OP_AND;
          default:           undecoded = 1'b1;
        endcase
      end
      // LUI is an add to x0
      OPC_LUI: begin
        dec.fu      = FU_ALU;
        dec.op      = OP_ADD;
        dec.rd      = w[11:7];
        dec.imm     = imm_u;
        dec.use_imm = 1'b1;
      end
      OPC_JAL: begin
        dec.fu      = FU_CTRL_FLOW;
        dec.op      = OP_JAL;
        dec.rd      = w[11:7];
        dec.imm     = imm_j;
        dec.use_imm = 1'b1;
      end
      OPC_JALR: begin
        dec.fu      = FU_CTRL_FLOW;
        dec.op      = OP_JALR;
        dec.rd      = w[11:7];
        dec.rs1     = w[19:15];
        dec.imm     = imm_i;
        dec.use_imm = 1'b1;
        undecoded   = (w[14:12] != F3_JALR);
      end
      OPC_BRANCH: begin
        dec.fu      = FU_CTRL_FLOW;
        dec.rs1     = w[19:15];
        dec.rs2     = w[24:20];
        dec.imm     = imm_b;
        dec.use_imm = 1'b1;
        case (w[14:12])
          F3_BEQ:  dec.op = OP_BEQ;
          F3_BNE:  dec.op = OP_BNE;
          F3_BLT:  dec.op = OP_BLT;
          F3_BGE:  dec.op = OP_BGE;
          default: undecoded = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        dec.fu      = FU_LOAD;
        dec.op      = OP_LW;
        dec.rd      = w[11:7];
        dec.rs1     = w[19:15];
        dec.imm     = imm_i;
        dec.use_imm = 1'b1;
        undecoded   = (w[14:12] != F3_WORD);
      end
      OPC_STORE: begin
        dec.fu      = FU_STORE;
        dec.op      = OP_SW;
        dec.rs1     = w[19:15];
        dec.rs2     = w[24:20];
        dec.imm     = imm_s;
        dec.use_imm = 1'b1;
        undecoded   = (w[14:12] != F3_WORD);
      end
      OPC_SYSTEM: begin
        dec.fu    = FU_CSR;
        ecall     = (w == INSTR_ECALL);
        mret      = (w == INSTR_MRET);
        dec.op    = mret ? OP_MRET : OP_ECALL;
        undecoded = !(ecall || mret);
      end
      default: undecoded = 1'b1;
    endcase
  end

  // MRET only returns from machine mode
  assign illegal = exp_i.illegal | undecoded | (mret & (priv_lvl_i != PRIV_M));

  // ----------------------------------------
  // Exception merge
  // ----------------------------------------
  always_comb begin
    sbe_o               = illegal ? '0 : dec;
    sbe_o.pc            = pc_i;
    sbe_o.is_compressed = exp_i.is_compressed;
    sbe_o.ex_valid      = fetch_ex_i | illegal | ecall;
    sbe_o.ex_cause      = '0;
    if (fetch_ex_i) begin
      sbe_o.ex_cause = CAUSE_INSTR_PAGE_FAULT;
    end else if (illegal) begin
      sbe_o.ex_cause = CAUSE_ILLEGAL_INSTR;
    end else if (ecall) begin
      sbe_o.ex_cause = (priv_lvl_i == PRIV_U) ? CAUSE_ECALL_U : CAUSE_ECALL_M;
    end
    // A trapping entry goes to no unit
    if (sbe_o.ex_valid) begin
      sbe_o.fu = FU_NONE;
    end
  end

  assign is_ctrl_flow_o = (sbe_o.fu == FU_CTRL_FLOW);

endmodule

/* verilog/issue_register.sv */
`timescale 1ns/1ns
// ID/issue pipeline register
// One slot with the fetch-side ready and the issue-side acknowledge

module issue_register (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              flush_i,
  input  logic              fetch_valid_i,
  output logic              fetch_ready_o,
  input  id_pkg::sb_entry_t sbe_i,
  input  id_pkg::instr_t    orig_instr_i,
  input  logic              is_ctrl_flow_i,
  input  logic              issue_ack_i,
  output id_pkg::sb_entry_t issue_entry_o,
  output logic              issue_valid_o,
  output id_pkg::instr_t    orig_instr_o,
  output logic              is_ctrl_flow_o
);
  import id_pkg::*;

  issue_slot_t slot_d;
  issue_slot_t slot_q;

  // Free now or freed by this cycle's acknowledge, and never during a flush
  assign fetch_ready_o = (~slot_q.valid | issue_ack_i) & ~flush_i;

  always_comb begin
    slot_d = slot_q;
    if (issue_ack_i) begin
      slot_d.valid = 1'b0;
    end
    if (fetch_valid_i && fetch_ready_o) begin
      slot_d = '{valid: 1'b1, sbe: sbe_i, orig_instr: orig_instr_i,
                 is_ctrl_flow: is_ctrl_flow_i};
    end
    if (flush_i) begin
      slot_d.valid = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_q <= '0;
    end else begin
      slot_q <= slot_d;
    end
  end

  assign issue_entry_o  = slot_q.sbe;
  assign issue_valid_o  = slot_q.valid;
  assign orig_instr_o   = slot_q.orig_instr;
  assign is_ctrl_flow_o = slot_q.is_ctrl_flow;

endmodule

/* verilog/id_stage.sv */
`timescale 1ns/1ns
// Instruction decode stage
// RVC expander, RV32I decoder and the ID/issue register in a chain

module id_stage #(
  parameter bit RvcEn = 1'b1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  id_pkg::fetch_entry_t fetch_entry_i,
  input  logic                 fetch_entry_valid_i,
  output logic                 fetch_entry_ready_o,
  input  id_pkg::priv_lvl_t    priv_lvl_i,
  output id_pkg::sb_entry_t    issue_entry_o,
  output logic                 issue_entry_valid_o,
  input  logic                 issue_instr_ack_i,
  output id_pkg::instr_t       orig_instr_o,
  output logic                 is_ctrl_flow_o
);
  import id_pkg::*;

  expanded_instr_t exp_instr;
  sb_entry_t       decoded;
  logic            decoded_ctrl_flow;

  compressed_decoder #(
    .RvcEn(RvcEn)
  ) compressed_decoder_i (
    .instr_i(fetch_entry_i.instruction),
    .exp_o  (exp_instr)
  );

  instr_decoder instr_decoder_i (
    .exp_i         (exp_instr),
    .pc_i          (fetch_entry_i.address),
    .fetch_ex_i    (fetch_entry_i.ex_valid),
    .priv_lvl_i    (priv_lvl_i),
    .sbe_o         (decoded),
    .is_ctrl_flow_o(decoded_ctrl_flow)
  );

  // The raw fetched word travels along, not the expansion
  issue_register issue_register_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .fetch_valid_i (fetch_entry_valid_i),
    .fetch_ready_o (fetch_entry_ready_o),
    .sbe_i         (decoded),
    .orig_instr_i  (fetch_entry_i.instruction),
    .is_ctrl_flow_i(decoded_ctrl_flow),
    .issue_ack_i   (issue_instr_ack_i),
    .issue_entry_o (issue_entry_o),
    .issue_valid_o (issue_entry_valid_o),
    .orig_instr_o  (orig_instr_o),
    .is_ctrl_flow_o(is_ctrl_flow_o)
  );

endmodule

/* include/id_ref_model.svh */
// Reference model for the decode stage testbench
// ref_expand turns a compressed half into its 32-bit word and an illegal flag
// ref_decode builds the expected scoreboard entry and control-flow bit
// Expects id_pkg to be imported by the including scope

`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

function automatic expanded_instr_t ref_expand(input cinstr_t c);
  expanded_instr_t e;
  logic [31:0]     ci;
  logic [31:0]     jo;
  logic [31:0]     bo;
  logic [31:0]     mo;
  logic [4:0]      r1p;
  logic [4:0]      r2p;
  ci  = {{27{c[12]}}, c[6:2]};
  jo  = {{21{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
  bo  = {{24{c[12]}}, c[6:5], c[2], c[11:10], c[4:3], 1'b0};
  mo  = {25'd0, c[5], c[12:10], c[6], 2'b00};
  r1p = {2'b01, c[9:7]};
  r2p = {2'b01, c[4:2]};
  e   = '{instr: {16'h0000, c}, is_compressed: 1'b1, illegal: 1'b0};
  case ({c[15:13], c[1:0]})
    5'b000_01: e.instr = {ci[11:0], c[11:7], 3'b000, c[11:7], 7'h13};
    5'b010_01: e.instr = {ci[11:0], 5'd0, 3'b000, c[11:7], 7'h13};
    5'b101_01: e.instr = {jo[20], jo[10:1], jo[11], jo[19:12], 5'd0, 7'h6f};
    5'b110_01: e.instr = {bo[12], bo[10:5], 5'd0, r1p, 3'b000, bo[4:1], bo[11], 7'h63};
    5'b111_01: e.instr = {bo[12], bo[10:5], 5'd0, r1p, 3'b001, bo[4:1], bo[11], 7'h63};
    5'b010_00: e.instr = {mo[11:0], r1p, 3'b010, r2p, 7'h03};
    5'b110_00: e.instr = {mo[11:5], r2p, r1p, 3'b010, mo[4:0], 7'h23};
    5'b100_10: begin
      if (c[6:2] == 5'd0) begin
        e.illegal = 1'b1;
      end else begin
        e.instr = {7'd0, c[6:2], (c[12] ? c[11:7] : 5'd0), 3'b000, c[11:7], 7'h33};
      end
    end
    default: e.illegal = 1'b1;
  endcase
  return e;
endfunction

function automatic sb_entry_t ref_decode(input fetch_entry_t fe, input priv_lvl_t priv,
                                         output logic ctrl);
  expanded_instr_t e;
  sb_entry_t       s;
  instr_t          w;
  logic [2:0]      fmt;
  logic            bad;
  logic            ecall;
  if (fe.instruction[1:0] == 2'b11) begin
    e = '{instr: fe.instruction, is_compressed: 1'b0, illegal: 1'b0};
  end else begin
    e = ref_expand(fe.instruction[15:0]);
  end
  w     = e.instr;
  s     = '0;
  fmt   = 3'd0;
  bad   = e.illegal;
  ecall = (w == 32'h0000_0073);
  // Formats 1 R, 2 I, 3 U, 4 J, 5 B, 6 S
  casez ({w[31:25], w[14:12], w[6:0]})
    17'b???????_000_0010011: {s.fu, s.op, fmt} = {FU_ALU, OP_ADD, 3'd2};
    17'b???????_010_0010011: {s.fu, s.op, fmt} = {FU_ALU, OP_SLT, 3'd2};
    17'b???????_100_0010011: {s.fu, s.op, fmt} = {FU_ALU, OP_XOR, 3'd2};
    17'b???????_110_0010011: {s.fu, s.op, fmt} = {FU_ALU, OP_OR, 3'd2};
    17'b???????_111_0010011: {s.fu, s.op, fmt} = {FU_ALU, OP_AND, 3'd2};
    17'b0000000_000_0110011: {s.fu, s.op, fmt} = {FU_ALU, OP_ADD, 3'd1};
    17'b0100000_000_0110011: {s.fu, s.op, fmt} = {FU_ALU, OP_SUB, 3'd1};
    17'b0000000_010_0110011: {s.fu, s.op, fmt} = {FU_ALU, OP_SLT, 3'd1};
    17'b0000000_100_0110011: {s.fu, s.op, fmt} = {FU_ALU, OP_XOR, 3'd1};
    17'b0000000_110_0110011: {s.fu, s.op, fmt} = {FU_ALU, OP_OR, 3'd1};
    17'b0000000_111_0110011: {s.fu, s.op, fmt} = {FU_ALU, OP_AND, 3'd1};
    17'b???????_???_0110111: {s.fu, s.op, fmt} = {FU_ALU, OP_ADD, 3'd3};
    17'b???????_???_1101111: {s.fu, s.op, fmt} = {FU_CTRL_FLOW, OP_JAL, 3'd4};
    17'b???????_000_1100111: {s.fu, s.op, fmt} = {FU_CTRL_FLOW, OP_JALR, 3'd2};
    17'b???????_000_1100011: {s.fu, s.op, fmt} = {FU_CTRL_FLOW, OP_BEQ, 3'd5};
    17'b???????_001_1100011: {s.fu, s.op, fmt} = {FU_CTRL_FLOW, OP_BNE, 3'd5};
    17'b???????_100_1100011: {s.fu, s.op, fmt} = {FU_CTRL_FLOW, OP_BLT, 3'd5};
    17'b???????_101_1100011: {s.fu, s.op, fmt} = {FU_CTRL_FLOW, OP_BGE, 3'd5};
    17'b???????_010_0000011: {s.fu, s.op, fmt} = {FU_LOAD, OP_LW, 3'd2};
    17'b???????_010_0100011: {s.fu, s.op, fmt} = {FU_STORE, OP_SW, 3'd6};
    default: begin
      if (ecall) begin
        {s.fu, s.op} = {FU_CSR, OP_ECALL};
      end else if ((w == 32'h3020_0073) && (priv == PRIV_M)) begin
        {s.fu, s.op} = {FU_CSR, OP_MRET};
      end else begin
        bad = 1'b1;
      end
    end
  endcase
  s.rd      = (fmt inside {3'd1, 3'd2, 3'd3, 3'd4}) ? w[11:7] : 5'd0;
  s.rs1     = (fmt inside {3'd1, 3'd2, 3'd5, 3'd6}) ? w[19:15] : 5'd0;
  s.rs2     = (fmt inside {3'd1, 3'd5, 3'd6}) ? w[24:20] : 5'd0;
  s.use_imm = (fmt > 3'd1);
  case (fmt)
    3'd2:    s.imm = {{20{w[31]}}, w[31:20]};
    3'd3:    s.imm = {w[31:12], 12'h000};
    3'd4:    s.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    3'd5:    s.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    3'd6:    s.imm = {{20{w[31]}}, w[31:25], w[11:7]};
    default: s.imm = '0;
  endcase
  if (bad) begin
    s = '0;
  end
  s.pc            = fe.address;
  s.is_compressed = e.is_compressed;
  s.ex_valid      = fe.ex_valid | bad | ecall;
  if (fe.ex_valid) begin
    s.ex_cause = CAUSE_INSTR_PAGE_FAULT;
  end else if (bad) begin
    s.ex_cause = CAUSE_ILLEGAL_INSTR;
  end else if (ecall) begin
    s.ex_cause = (priv == PRIV_U) ? CAUSE_ECALL_U : CAUSE_ECALL_M;
  end
  if (s.ex_valid) begin
    s.fu = FU_NONE;
  end
  ctrl = (s.fu == FU_CTRL_FLOW);
  return s;
endfunction

`endif

/* dv/tb_id_stage.sv */
`timescale 1ns/1ns
// Testbench for the decode stage
// Random RV32I and RVC streams, exception cases, back-pressure and flush
// Expected entries come from the reference model and are checked in issue order
// Ends with the error counts and the final verdict

module tb_id_stage;
  import id_pkg::*;

`include "id_ref_model.svh"

  localparam int SEED = 76488;
  // The six tests take about 1500 cycles
  localparam int TIMEOUT_CYCLES = 4 * 1500;

  logic         clk_i = 1'b0;
  logic         rst_ni = 1'b0;
  logic         flush_i = 1'b0;
  fetch_entry_t fetch_entry_i = '0;
  logic         fetch_entry_valid_i = 1'b0;
  logic         fetch_entry_ready_o;
  priv_lvl_t    priv_lvl_i = PRIV_M;
  sb_entry_t    issue_entry_o;
  logic         issue_entry_valid_o;
  logic         issue_instr_ack_i = 1'b0;
  instr_t       orig_instr_o;
  logic         is_ctrl_flow_o;

  issue_slot_t  exp_q[$];
  issue_slot_t  held = '0;
  logic         accepted_last = 1'b0;
  int           seed = SEED;
  int           ack_seed = SEED + 1;
  // 0 acknowledges every cycle, 1 leaves random gaps, 2 never acknowledges
  int           ack_mode = 2;
  int           seq_err = 0;
  int           cap_err = 0;
  int           cmp_err = 0;
  int           compared = 0;
  int           cycles = 0;
  addr_t        pc = 32'h0000_1000;

  id_stage #(
    .RvcEn(1'b1)
  ) id_stage_i (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .flush_i            (flush_i),
    .fetch_entry_i      (fetch_entry_i),
    .fetch_entry_valid_i(fetch_entry_valid_i),
    .fetch_entry_ready_o(fetch_entry_ready_o),
    .priv_lvl_i         (priv_lvl_i),
    .issue_entry_o      (issue_entry_o),
    .issue_entry_valid_o(issue_entry_valid_o),
    .issue_instr_ack_i  (issue_instr_ack_i),
    .orig_instr_o       (orig_instr_o),
    .is_ctrl_flow_o     (is_ctrl_flow_o)
  );

  always #10 clk_i = ~clk_i;

  // ----------------------------------------
  // Checks and random helpers
  // ----------------------------------------
  function automatic int check_value(input string name, input logic [31:0] exp_v,
                                     input logic [31:0] act_v);
    int bad;
    bad = 0;
    assert (exp_v === act_v) else begin
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
      bad = 1;
    end
    return bad;
  endfunction

  function automatic int compare_slot(input issue_slot_t e);
    int n;
    n = 0;
    n += check_value("issue_entry_o.pc", e.sbe.pc, issue_entry_o.pc);
    n += check_value("issue_entry_o.fu", 32'(e.sbe.fu), 32'(issue_entry_o.fu));
    n += check_value("issue_entry_o.op", 32'(e.sbe.op), 32'(issue_entry_o.op));
    n += check_value("issue_entry_o.rs1", 32'(e.sbe.rs1), 32'(issue_entry_o.rs1));
    n += check_value("issue_entry_o.rs2", 32'(e.sbe.rs2), 32'(issue_entry_o.rs2));
    n += check_value("issue_entry_o.rd", 32'(e.sbe.rd), 32'(issue_entry_o.rd));
    n += check_value("issue_entry_o.imm", e.sbe.imm, issue_entry_o.imm);
    n += check_value("issue_entry_o.use_imm", 32'(e.sbe.use_imm),
                     32'(issue_entry_o.use_imm));
    n += check_value("issue_entry_o.is_compressed", 32'(e.sbe.is_compressed),
                     32'(issue_entry_o.is_compressed));
    n += check_value("issue_entry_o.ex_valid", 32'(e.sbe.ex_valid),
                     32'(issue_entry_o.ex_valid));
    n += check_value("issue_entry_o.ex_cause", 32'(e.sbe.ex_cause),
                     32'(issue_entry_o.ex_cause));
    n += check_value("orig_instr_o", e.orig_instr, orig_instr_o);
    n += check_value("is_ctrl_flow_o", 32'(e.is_ctrl_flow), 32'(is_ctrl_flow_o));
    return n;
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  // One of the kept RV32I instructions, other fields random
  function automatic instr_t rand_instr32();
    logic [31:0] rw;
    instr_t      w;
    rw = $random(seed);
    case (rand_below(22))
      0:  w = {rw[31:15], 3'b000, rw[11:7], OPC_OP_IMM};
      1:  w = {rw[31:15], 3'b010, rw[11:7], OPC_OP_IMM};
      2:  w = {rw[31:15], 3'b100, rw[11:7], OPC_OP_IMM};
      3:  w = {rw[31:15], 3'b110, rw[11:7], OPC_OP_IMM};
      4:  w = {rw[31:15], 3'b111, rw[11:7], OPC_OP_IMM};
      5:  w = {7'b0000000, rw[24:15], 3'b000, rw[11:7], OPC_OP};
      6:  w = {7'b0100000, rw[24:15], 3'b000, rw[11:7], OPC_OP};
      7:  w = {7'b0000000, rw[24:15], 3'b010, rw[11:7], OPC_OP};
      8:  w = {7'b0000000, rw[24:15], 3'b100, rw[11:7], OPC_OP};
      9:  w = {7'b0000000, rw[24:15], 3'b110, rw[11:7], OPC_OP};
      10: w = {7'b0000000, rw[24:15], 3'b111, rw[11:7], OPC_OP};
      11: w = {rw[31:7], OPC_LUI};
      12: w = {rw[31:7], OPC_JAL};
      13: w = {rw[31:15], 3'b000, rw[11:7], OPC_JALR};
      14: w = {rw[31:15], 3'b000, rw[11:7], OPC_BRANCH};
      15: w = {rw[31:15], 3'b001, rw[11:7], OPC_BRANCH};
      16: w = {rw[31:15], 3'b100, rw[11:7], OPC_BRANCH};
      17: w = {rw[31:15], 3'b101, rw[11:7], OPC_BRANCH};
      18: w = {rw[31:15], 3'b010, rw[11:7], OPC_LOAD};
      19: w = {rw[31:15], 3'b010, rw[11:7], OPC_STORE};
      20: w = 32'h0000_0073;
      default: w = 32'h3020_0073;
    endcase
    return w;
  endfunction

  // One of the kept RVC encodings in the low half
  function automatic instr_t rand_instr16();
    logic [31:0] rw;
    cinstr_t     c;
    rw = $random(seed);
    case (rand_below(8))
      0: c = {3'b000, rw[12:2], 2'b01};
      1: c = {3'b010, rw[12:2], 2'b01};
      2: c = {3'b101, rw[12:2], 2'b01};
      3: c = {3'b110, rw[12:2], 2'b01};
      4: c = {3'b111, rw[12:2], 2'b01};
      5: c = {3'b010, rw[12:2], 2'b00};
      6: c = {3'b110, rw[12:2], 2'b00};
      default: begin
        // C.MV or C.ADD by bit 12, rs2 kept nonzero
        c = {3'b100, rw[12:2], 2'b10};
        if (c[6:2] == 5'd0) begin
          c[6:2] = 5'd1;
        end
      end
    endcase
    return {16'h0000, c};
  endfunction

  function automatic instr_t rand_mixed();
    return (rand_below(2) == 0) ? rand_instr32() : rand_instr16();
  endfunction

  function automatic int total_errors();
    return seq_err + cap_err + cmp_err;
  endfunction

  // ----------------------------------------
  // Stimulus tasks
  // ----------------------------------------
  // Presents one entry after a random gap and returns on the falling edge after it is taken
  task automatic send_entry(input instr_t w, input logic fetch_ex);
    repeat (rand_below(3)) @(negedge clk_i);
    fetch_entry_i       <= '{address: pc, instruction: w, ex_valid: fetch_ex};
    fetch_entry_valid_i <= 1'b1;
    @(posedge clk_i);
    while (!fetch_entry_ready_o) begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
    fetch_entry_valid_i <= 1'b0;
    pc = pc + ((w[1:0] == 2'b11) ? 32'd4 : 32'd2);
  endtask

  task automatic drain();
    ack_mode <= 0;
    @(negedge clk_i);
    while (issue_entry_valid_o) begin
      @(negedge clk_i);
    end
    assert (exp_q.size() == 0) else begin
      $display("Accepted entries were never issued at %0t ns", $time);
      seq_err++;
    end
  endtask

  task automatic report_test(input string name, input int err0, input int cmp0);
    $display("Test %s: %0d entries compared, %0d errors", name, compared - cmp0,
             total_errors() - err0);
  endtask

  // ----------------------------------------
  // Expected queue and comparison
  // ----------------------------------------
  always @(posedge clk_i) begin : capture
    issue_slot_t s;
    logic        ctrl;
    if (rst_ni) begin
      // An accepted entry must be presented on the next cycle
      if (accepted_last) begin
        cap_err += check_value("issue_entry_valid_o", 32'd1, 32'(issue_entry_valid_o));
      end
      accepted_last = fetch_entry_valid_i && fetch_entry_ready_o;
      if (accepted_last) begin
        s.valid        = 1'b1;
        s.sbe          = ref_decode(fetch_entry_i, priv_lvl_i, ctrl);
        s.orig_instr   = fetch_entry_i.instruction;
        s.is_ctrl_flow = ctrl;
        exp_q.push_back(s);
      end
    end
  end

  always @(posedge clk_i) begin : compare
    issue_slot_t e;
    if (rst_ni) begin
      if (held.valid && issue_entry_valid_o) begin
        assert ({issue_entry_o, orig_instr_o, is_ctrl_flow_o} ===
                {held.sbe, held.orig_instr, held.is_ctrl_flow}) else begin
          $display("Error at %0t ns: issue outputs expected %h, got %h", $time,
                   {held.sbe, held.orig_instr, held.is_ctrl_flow},
                   {issue_entry_o, orig_instr_o, is_ctrl_flow_o});
          cmp_err++;
        end
      end
      held.valid = 1'b0;
      if (issue_entry_valid_o && !issue_instr_ack_i) begin
        cmp_err += check_value("fetch_entry_ready_o", 32'd0, 32'(fetch_entry_ready_o));
        held = '{valid: 1'b1, sbe: issue_entry_o, orig_instr: orig_instr_o,
                 is_ctrl_flow: is_ctrl_flow_o};
      end
      if (issue_entry_valid_o && issue_instr_ack_i) begin
        assert (exp_q.size() != 0) else begin
          $display("Entry issued at %0t ns that was never accepted or was flushed", $time);
          cmp_err++;
        end
        if (exp_q.size() != 0) begin
          e = exp_q.pop_front();
          cmp_err += compare_slot(e);
          compared++;
        end
      end
      if (flush_i) begin
        cmp_err += check_value("fetch_entry_ready_o", 32'd0, 32'(fetch_entry_ready_o));
        exp_q.delete();
      end
    end
  end

  always @(negedge clk_i) begin
    case (ack_mode)
      0:       issue_instr_ack_i <= 1'b1;
      1:       issue_instr_ack_i <= (($unsigned($random(ack_seed)) % 3) != 0);
      default: issue_instr_ack_i <= 1'b0;
    endcase
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    int err0;
    int cmp0;
    repeat (4) @(negedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);

    err0 = total_errors();
    cmp0 = compared;
    seq_err += check_value("issue_entry_valid_o", 32'd0, 32'(issue_entry_valid_o));
    seq_err += check_value("fetch_entry_ready_o", 32'd1, 32'(fetch_entry_ready_o));
    report_test("1 reset", err0, cmp0);

    err0 = total_errors();
    cmp0 = compared;
    ack_mode <= 0;
    repeat (300) send_entry(rand_instr32(), 1'b0);
    drain();
    report_test("2 random RV32I", err0, cmp0);

    err0 = total_errors();
    cmp0 = compared;
    repeat (200) send_entry(rand_instr16(), 1'b0);
    drain();
    report_test("3 random RVC", err0, cmp0);

    // Unsupported words, the zero half-word, fetch faults, ECALL and MRET
    err0 = total_errors();
    cmp0 = compared;
    send_entry(32'h0000_0000, 1'b0);
    send_entry(32'hffff_ffff, 1'b0);
    send_entry(32'h0010_1093, 1'b0);
    send_entry(32'h0220_80b3, 1'b0);
    send_entry(32'h3000_2573, 1'b0);
    send_entry(32'h0000_8082, 1'b0);
    send_entry(32'h0000_0040, 1'b0);
    repeat (8) send_entry(rand_mixed(), 1'b1);
    priv_lvl_i <= PRIV_U;
    send_entry(32'h0000_0073, 1'b0);
    send_entry(32'h3020_0073, 1'b0);
    priv_lvl_i <= PRIV_M;
    send_entry(32'h0000_0073, 1'b0);
    send_entry(32'h3020_0073, 1'b0);
    drain();
    report_test("4 exceptions", err0, cmp0);

    err0 = total_errors();
    cmp0 = compared;
    ack_mode <= 1;
    repeat (150) send_entry(rand_mixed(), 1'b0);
    drain();
    report_test("5 back-pressure", err0, cmp0);

    err0 = total_errors();
    cmp0 = compared;
    repeat (10) begin
      ack_mode <= 2;
      send_entry(rand_mixed(), 1'b0);
      // The entry sits unacknowledged in the register and is dropped
      flush_i <= 1'b1;
      @(negedge clk_i);
      flush_i <= 1'b0;
      seq_err += check_value("issue_entry_valid_o", 32'd0, 32'(issue_entry_valid_o));
      ack_mode <= 0;
      repeat (4) send_entry(rand_mixed(), 1'b0);
      drain();
      // A flush with an entry waiting on the empty register loads nothing
      flush_i             <= 1'b1;
      fetch_entry_valid_i <= 1'b1;
      @(negedge clk_i);
      flush_i             <= 1'b0;
      fetch_entry_valid_i <= 1'b0;
      seq_err += check_value("issue_entry_valid_o", 32'd0, 32'(issue_entry_valid_o));
    end
    report_test("6 flush", err0, cmp0);

    $display("Compared %0d entries in total, %0d errors", compared, total_errors());
    if (total_errors() == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+include
verilog/id_pkg.sv
verilog/compressed_decoder.sv
verilog/instr_decoder.sv
verilog/issue_register.sv
verilog/id_stage.sv
dv/tb_id_stage.sv

/* Makefile */
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
